/* build.f */
hw/alignPkg.sv
hw/pipeMemory.sv
hw/fastFifo.sv
hw/streamSynchronizer.sv
hw/lookaheadReg.sv
hw/alignedStreams.sv
tb/alignedStreams_assert.sv
tb/alignedStreamsTb.sv

/* hw/alignPkg.sv */
package alignPkg;

    // Stream layout
    localparam int NUM_STREAMS = 3;
    localparam int DATA_WIDTH = 16;

    // FIFO geometry, one slot is always kept free
    localparam int DEPTH_LOG2 = 5;
    localparam int FIFO_DEPTH = 1 << DEPTH_LOG2;

    // Cycles from read request to valid data
    localparam int READ_LATENCY = 4;

    // Minimum spacing of synchronizer reads
    localparam int READ_PERIOD = 3;
    localparam int PHASE_WIDTH = $clog2(READ_PERIOD);

    // Free-word threshold for almostFull
    localparam int ALMOST_FULL_MARGIN = 8;

    typedef logic [DEPTH_LOG2-1:0] fifoAddr_t;

    typedef logic [PHASE_WIDTH-1:0] phase_t;

    // One word of a single stream
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
    } streamWord_t;

    // One word per stream, stream 0 in the low field
    typedef struct packed {
        streamWord_t [NUM_STREAMS-1:0] words;
    } alignedSet_t;

endpackage

/* hw/alignedStreams.sv */
module alignedStreams (
    input  logic                                            rdclk,
    input  logic                                            rst,

    // Stream inputs
    input  logic [alignPkg::NUM_STREAMS-1:0]                streamWrite,
    input  alignPkg::streamWord_t [alignPkg::NUM_STREAMS-1:0] streamData,
    output logic [alignPkg::NUM_STREAMS-1:0]                streamAlmostFull,

    // Aligned output
    input  logic                                            grab,
    output logic                                            setAvailable,
    output alignPkg::alignedSet_t                           setOut
);

    logic [alignPkg::NUM_STREAMS-1:0] streamEmpty;
    logic [alignPkg::NUM_STREAMS-1:0] streamValid;
    alignPkg::streamWord_t [alignPkg::NUM_STREAMS-1:0] streamOut;
    logic readPulse;

    alignPkg::alignedSet_t readSet;
    alignPkg::alignedSet_t outFifoData;
    logic outAlmostFull;
    logic outEmpty;
    logic outRead;
    logic outValid;

    // One FIFO per stream, all read together
    for (genvar i = 0; i < alignPkg::NUM_STREAMS; i++) begin : g_stream
        fastFifo #(
            .payloadType(alignPkg::streamWord_t)
        ) i_streamFifo (
            .rdclk       (rdclk),
            .rst         (rst),
            .writeEnable (streamWrite[i]),
            .dataIn      (streamData[i]),
            .almostFull  (streamAlmostFull[i]),
            .readRequest (readPulse),
            .dataOut     (streamOut[i]),
            .dataOutValid(streamValid[i]),
            .empty       (streamEmpty[i])
        );
    end

    streamSynchronizer i_sync (
        .rdclk           (rdclk),
        .rst             (rst),
        .streamEmpty     (streamEmpty),
        .outputAlmostFull(outAlmostFull),
        .readPulse       (readPulse)
    );

    // Words return together, stream 0 valid stands for the set
    assign readSet.words = streamOut;

    fastFifo #(
        .payloadType(alignPkg::alignedSet_t)
    ) i_outFifo (
        .rdclk       (rdclk),
        .rst         (rst),
        .writeEnable (streamValid[0]),
        .dataIn      (readSet),
        .almostFull  (outAlmostFull),
        .readRequest (outRead),
        .dataOut     (outFifoData),
        .dataOutValid(outValid),
        .empty       (outEmpty)
    );

    lookaheadReg #(
        .payloadType(alignPkg::alignedSet_t)
    ) i_outReg (
        .rdclk        (rdclk),
        .rst          (rst),
        .fifoEmpty    (outEmpty),
        .fifoData     (outFifoData),
        .fifoDataValid(outValid),
        .fifoRead     (outRead),
        .grab         (grab),
        .dataAvailable(setAvailable),
        .dataOut      (setOut)
    );

endmodule

/* hw/fastFifo.sv */
module fastFifo #(
    parameter type payloadType = logic
) (
    input  logic        rdclk,
    input  logic        rst,

    // Write side
    input  logic        writeEnable,
    input  payloadType  dataIn,
    output logic        almostFull,

    // Read side, caller only requests when not empty
    input  logic        readRequest,
    output payloadType  dataOut,
    output logic        dataOutValid,
    output logic        empty
);

    alignPkg::fifoAddr_t writeAddr;
    alignPkg::fifoAddr_t readAddr;
    alignPkg::fifoAddr_t readAddrNext;
    alignPkg::fifoAddr_t writesLeft;

    logic [alignPkg::READ_LATENCY-1:0] validPipe;

    // Read pointer marks the last slot that was read
    assign writesLeft = readAddr - writeAddr;
    assign empty = writesLeft == alignPkg::fifoAddr_t'(alignPkg::FIFO_DEPTH - 1);

    // Memory already addresses the slot being requested
    assign readAddrNext = readAddr + alignPkg::fifoAddr_t'(readRequest);

    always_ff @(posedge rdclk) begin
        if (rst) begin
            // Write head starts one ahead of the read head
            writeAddr <= alignPkg::fifoAddr_t'(1);
            readAddr <= '0;
            almostFull <= 1'b0;
            validPipe <= '0;
        end else begin
            writeAddr <= writeAddr + alignPkg::fifoAddr_t'(writeEnable);
            readAddr <= readAddrNext;
            almostFull <= writesLeft < alignPkg::fifoAddr_t'(alignPkg::ALMOST_FULL_MARGIN);
            validPipe <= {validPipe[alignPkg::READ_LATENCY-2:0], readRequest};
        end
    end

    // Valid travels alongside the memory pipeline
    assign dataOutValid = validPipe[alignPkg::READ_LATENCY-1];

    pipeMemory #(
        .payloadType(payloadType)
    ) i_memory (
        .rdclk      (rdclk),
        .writeEnable(writeEnable),
        .writeAddr  (writeAddr),
        .dataIn     (dataIn),
        .readAddr   (readAddrNext),
        .dataOut    (dataOut)
    );

endmodule

/* hw/lookaheadReg.sv */
module lookaheadReg #(
    parameter type payloadType = logic
) (
    input  logic        rdclk,
    input  logic        rst,

    // Read side of the FIFO
    input  logic        fifoEmpty,
    input  payloadType  fifoData,
    input  logic        fifoDataValid,
    output logic        fifoRead,

    // Consumer side
    input  logic        grab,
    output logic        dataAvailable,
    output payloadType  dataOut
);

    // Set a read is pending, a second read would overwrite it
    logic inFlight;

    assign fifoRead = !fifoEmpty && (grab || (!dataAvailable && !inFlight));

    always_ff @(posedge rdclk) begin
        if (rst) begin
            dataAvailable <= 1'b0;
            inFlight <= 1'b0;
        end else begin
            if (grab) begin
                dataAvailable <= 1'b0;
            end else if (fifoDataValid) begin
                dataAvailable <= 1'b1;
                inFlight <= 1'b0;
            end
            // Never coincides with a returning valid
            if (fifoRead) begin
                inFlight <= 1'b1;
            end
        end
    end

    always_ff @(posedge rdclk) begin
        if (fifoDataValid) begin
            dataOut <= fifoData;
        end
    end

endmodule

/* hw/pipeMemory.sv */
module pipeMemory #(
    parameter type payloadType = logic
) (
    input  logic                    rdclk,

    // Write port
    input  logic                    writeEnable,
    input  alignPkg::fifoAddr_t     writeAddr,
    input  payloadType              dataIn,

    // Read port, read every cycle
    input  alignPkg::fifoAddr_t     readAddr,
    output payloadType              dataOut
);

    payloadType memArray [alignPkg::FIFO_DEPTH];

    // Registered read followed by output stages
    payloadType readStages [alignPkg::READ_LATENCY];

    always_ff @(posedge rdclk) begin
        if (writeEnable) begin
            memArray[writeAddr] <= dataIn;
        end
    end

    always_ff @(posedge rdclk) begin
        readStages[0] <= memArray[readAddr];
        for (int i = 1; i < alignPkg::READ_LATENCY; i++) begin
            readStages[i] <= readStages[i-1];
        end
    end

    assign dataOut = readStages[alignPkg::READ_LATENCY-1];

endmodule

/* hw/streamSynchronizer.sv */
module streamSynchronizer (
    input  logic                              rdclk,
    input  logic                              rst,

    // Stream FIFO levels
    input  logic [alignPkg::NUM_STREAMS-1:0]  streamEmpty,

    // Output FIFO level
    input  logic                              outputAlmostFull,

    // Common read of all stream FIFOs
    output logic                              readPulse
);

    alignPkg::phase_t phase;
    logic allHaveData;
    logic readNow;

    assign allHaveData = ~|streamEmpty;

    // Only one read slot per period
    assign readNow = (phase == '0) && allHaveData && !outputAlmostFull;

    // Free-running phase counter
    always_ff @(posedge rdclk) begin
        if (rst) begin
            phase <= '0;
        end else if (phase == alignPkg::phase_t'(alignPkg::READ_PERIOD - 1)) begin
            phase <= '0;
        end else begin
            phase <= phase + alignPkg::phase_t'(1);
        end
    end

    // Registered decision gives a clean single-cycle pulse
    always_ff @(posedge rdclk) begin
        if (rst) begin
            readPulse <= 1'b0;
        end else begin
            readPulse <= readNow;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module alignedStreamsTb \
    -f build.f \
    -o simAlignedStreams

./obj_dir/simAlignedStreams 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"

/* tb/alignedStreamsTb.sv */
module alignedStreamsTb;

    localparam int CLK_PERIOD = 100;
    localparam int RANDOM_CYCLES = 600;
    localparam int STARVE_CYCLES = 500;
    localparam int STALL_CYCLES = 300;
    localparam int LOOKAHEAD_CYCLES = 400;
    localparam int SETTLE_CYCLES = 50;
    // At most one word per stream per stimulus cycle
    localparam int TEST_WORDS = RANDOM_CYCLES + STARVE_CYCLES + STALL_CYCLES + LOOKAHEAD_CYCLES;
    localparam int SLACK = 4;
    localparam int WATCHDOG_TIME = TEST_WORDS * alignPkg::READ_PERIOD * SLACK * CLK_PERIOD;

    logic rdclk;
    logic rst;
    logic [alignPkg::NUM_STREAMS-1:0] streamWrite;
    alignPkg::streamWord_t [alignPkg::NUM_STREAMS-1:0] streamData;
    logic [alignPkg::NUM_STREAMS-1:0] streamAlmostFull;
    logic grab;
    logic setAvailable;
    alignPkg::alignedSet_t setOut;

    // Reference model, words written but not yet delivered
    logic [alignPkg::DATA_WIDTH-1:0] pending [alignPkg::NUM_STREAMS][$];
    int writtenCount [alignPkg::NUM_STREAMS];
    int setCount;
    int errorCount;
    int assertCount;
    int seed;
    logic [alignPkg::NUM_STREAMS-1:0] sawAlmostFull;

    alignedStreams i_dut (
        .rdclk           (rdclk),
        .rst             (rst),
        .streamWrite     (streamWrite),
        .streamData      (streamData),
        .streamAlmostFull(streamAlmostFull),
        .grab            (grab),
        .setAvailable    (setAvailable),
        .setOut          (setOut)
    );

    initial begin
        rdclk = 1'b0;
        forever #(CLK_PERIOD / 2) rdclk = ~rdclk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired at %0t, the run did not complete", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic logic rollChance(input int outOf16);
        logic [31:0] r;
        r = $random(seed);
        return int'(r[3:0]) < outOf16;
    endfunction

    function automatic int fewestWritten();
        int fewest;
        fewest = writtenCount[0];
        for (int i = 1; i < alignPkg::NUM_STREAMS; i++) begin
            if (writtenCount[i] < fewest) begin
                fewest = writtenCount[i];
            end
        end
        return fewest;
    endfunction

    task automatic compareSet(input alignPkg::alignedSet_t got);
        for (int i = 0; i < alignPkg::NUM_STREAMS; i++) begin
            assert (pending[i].size() > 0) else begin
                errorCount++;
                $display("Set delivered at %0t while stream %0d had no word pending", $time, i);
            end
            if (pending[i].size() > 0) begin
                assert (got.words[i].data == pending[i][0]) else begin
                    errorCount++;
                    $display("[FAIL] %0t: stream %0d word %h, expected %h",
                             $time, i, got.words[i].data, pending[i][0]);
                end
                void'(pending[i].pop_front());
            end
        end
        setCount++;
    endtask

    // Sample at the falling edge, drive at the next rising edge
    task automatic stepCycle(input int writeChance, input int grabChance, input int starved);
        logic [alignPkg::NUM_STREAMS-1:0] nextWrite;
        alignPkg::streamWord_t [alignPkg::NUM_STREAMS-1:0] nextData;
        logic nextGrab;
        logic [31:0] r;
        @(negedge rdclk);
        sawAlmostFull = sawAlmostFull | streamAlmostFull;
        // DUT takes this set at the coming edge
        if (grab && setAvailable) begin
            compareSet(setOut);
        end
        for (int i = 0; i < alignPkg::NUM_STREAMS; i++) begin
            r = $random(seed);
            nextData[i].data = r[alignPkg::DATA_WIDTH-1:0];
            nextWrite[i] = rollChance(writeChance) && !streamAlmostFull[i] && i != starved;
            if (nextWrite[i]) begin
                pending[i].push_back(nextData[i].data);
                writtenCount[i]++;
            end
        end
        // Grab only a set already seen, never two cycles in a row
        nextGrab = !grab && setAvailable && rollChance(grabChance);
        @(posedge rdclk);
        streamWrite <= nextWrite;
        streamData <= nextData;
        grab <= nextGrab;
    endtask

    initial begin
        seed = 32'h9be2;
        rst = 1'b1;
        streamWrite = '0;
        streamData = '0;
        grab = 1'b0;
        setCount = 0;
        errorCount = 0;
        sawAlmostFull = '0;
        for (int i = 0; i < alignPkg::NUM_STREAMS; i++) begin
            writtenCount[i] = 0;
        end
        repeat (2) @(posedge rdclk);
        rst <= 1'b0;

        @(negedge rdclk);
        assert (!setAvailable && streamAlmostFull == '0) else begin
            errorCount++;
            $display("[FAIL] %0t: outputs not idle after reset", $time);
        end

        repeat (RANDOM_CYCLES) stepCycle(8, 8, -1);

        // Stream 1 starved, its words already written still drain out
        repeat (STARVE_CYCLES) stepCycle(8, 16, 1);
        assert (pending[1].size() == 0) else begin
            errorCount++;
            $display("Sets stopped with %0d words of stream 1 still pending", pending[1].size());
        end

        // Consumer stalls while writers keep going
        sawAlmostFull = '0;
        repeat (STALL_CYCLES) stepCycle(12, 0, -1);
        assert (sawAlmostFull == '1) else begin
            errorCount++;
            $display("almostFull never rose on streams %b during the stall", ~sawAlmostFull);
        end

        // Rare single grabs against a full pipeline
        repeat (LOOKAHEAD_CYCLES) stepCycle(12, 1, -1);

        // Writes stop, every complete set must come out
        while (setCount < fewestWritten()) begin
            stepCycle(0, 16, -1);
        end
        repeat (SETTLE_CYCLES) stepCycle(0, 16, -1);
        assert (setCount == fewestWritten()) else begin
            errorCount++;
            $display("[FAIL] %0t: %0d sets delivered, expected %0d",
                     $time, setCount, fewestWritten());
        end

        assertCount = i_dut.i_assert.emptyReadFailures + i_dut.i_assert.spacingFailures
                    + i_dut.i_assert.holdFailures;
        $display("Sets checked: %0d, check errors: %0d, assertion failures: %0d",
                 setCount, errorCount, assertCount);
        if (errorCount == 0 && assertCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb/alignedStreams_assert.sv */
module alignedStreamsAssert (
    input logic                             rdclk,
    input logic                             rst,
    input logic [alignPkg::NUM_STREAMS-1:0] streamEmpty,
    input logic                             readPulse,
    input logic                             grab,
    input logic                             setAvailable
);

    int cyclesSincePulse;
    int emptyReadFailures = 0;
    int spacingFailures = 0;
    int holdFailures = 0;

    // Cycles since the last synchronizer pulse, saturating
    always_ff @(posedge rdclk) begin
        if (rst) begin
            cyclesSincePulse <= alignPkg::READ_PERIOD;
        end else if (readPulse) begin
            cyclesSincePulse <= 1;
        end else if (cyclesSincePulse < alignPkg::READ_PERIOD) begin
            cyclesSincePulse <= cyclesSincePulse + 1;
        end
    end

    // All stream FIFOs are read together, so none may be empty
    readWhileEmpty: assert property (@(posedge rdclk) disable iff (rst)
        readPulse |-> streamEmpty == '0)
    else begin
        emptyReadFailures++;
        $error("Stream FIFO read while empty, empty flags %b", streamEmpty);
    end

    pulseSpacing: assert property (@(posedge rdclk) disable iff (rst)
        readPulse |-> cyclesSincePulse >= alignPkg::READ_PERIOD)
    else begin
        spacingFailures++;
        $error("Synchronizer pulses closer than the read period");
    end

    // Held set only goes away through grab
    holdUntilGrab: assert property (@(posedge rdclk) disable iff (rst)
        setAvailable && !grab |=> setAvailable)
    else begin
        holdFailures++;
        $error("setAvailable dropped without grab");
    end

endmodule

bind alignedStreams alignedStreamsAssert i_assert (
    .rdclk       (rdclk),
    .rst         (rst),
    .streamEmpty (streamEmpty),
    .readPulse   (readPulse),
    .grab        (grab),
    .setAvailable(setAvailable)
);
